//--- Makefile
# Verilator build and run for the pc defender testbench

TOP := pc_defender_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f

# the run passes only if the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

//--- design/bot_health.sv
// ======================================================================
// bot health
// detects player overlap, paces hits with a divider and counts the
// bot's health down to zero, revive restores full health
// ======================================================================
`timescale 1ns/1ps

module bot_health #(
    parameter int HIT_TICKS = 8
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              revive,
    input  screen_pkg::x_t    player_x,
    input  screen_pkg::y_t    player_y,
    input  screen_pkg::x_t    bot_x,
    input  screen_pkg::y_t    bot_y,
    output play_pkg::health_t health,
    output logic              alive
);

    localparam int HW = (HIT_TICKS > 1) ? $clog2(HIT_TICKS) : 1;
    localparam logic [HW-1:0] HIT_LAST = HW'(HIT_TICKS - 1);

    logic          overlap;
    logic [HW-1:0] hit_count;

    // same pixel means a collision
    assign overlap = (player_x == bot_x) && (player_y == bot_y);

    always_ff @(posedge clock)
    begin
        if (reset || revive)
        begin
            health    <= play_pkg::FULL_HEALTH;
            hit_count <= '0;
        end
        else if (overlap)
        begin
            if (hit_count == HIT_LAST)
            begin
                hit_count <= '0;
                if (health != '0)
                    health <= health - 1'b1;  // one point per hit period
            end
            else
            begin
                hit_count <= hit_count + 1'b1;
            end
        end
        // no overlap, divider and health hold
    end

    assign alive = (health != '0);

endmodule

//--- design/pc_defender_top.sv
// ======================================================================
// pc defender top level
// player and falling bots on a shared step timer, per-bot health,
// the score timer and the merged pixel write stream
// ======================================================================
`timescale 1ns/1ps

module pc_defender_top #(
    parameter int N_BOTS      = 3,
    parameter int STEP_TICKS  = 32,
    parameter int HIT_TICKS   = 8,
    parameter int SCORE_TICKS = 64
) (
    input  logic                                clock,
    input  logic                                reset,
    input  play_pkg::move_t                     player_move,
    input  logic [N_BOTS-1:0]                   bot_revive,
    output screen_pkg::pixel_t                  pixel,
    output play_pkg::health_t [N_BOTS-1:0]      bot_health,
    output play_pkg::score_t                    score
);

    logic [$clog2(STEP_TICKS)-1:0] step_count;
    screen_pkg::x_t                player_x;
    screen_pkg::y_t                player_y;
    screen_pkg::pixel_t [N_BOTS:0] pixel_req;   // 0 player, i+1 bot i
    logic [N_BOTS-1:0]             bot_alive;

    step_timer #(.STEP_TICKS(STEP_TICKS)) u_step_timer (
        .clock      (clock),
        .reset      (reset),
        .step_count (step_count)
    );

    sprite_mover #(
        .STEP_TICKS    (STEP_TICKS),
        .SPRITE_INDEX  (0),
        .START_X       (play_pkg::PLAYER_START_X),
        .START_Y       (screen_pkg::BOTTOM_ROW),
        .SPRITE_COLOUR (screen_pkg::COLOUR_PLAYER),
        .IS_PLAYER     (1'b1)
    ) u_player (
        .clock      (clock),
        .reset      (reset),
        .step_count (step_count),
        .move_req   (player_move),
        .pos_x      (player_x),
        .pos_y      (player_y),
        .pixel_req  (pixel_req[0])
    );

    for (genvar i = 0; i < N_BOTS; i++)
    begin : g_bot
        play_pkg::move_t bot_move;
        screen_pkg::x_t  bot_x;
        screen_pkg::y_t  bot_y;

        // a live bot always asks to fall
        assign bot_move = '{right: 1'b0, left: 1'b0, down: bot_alive[i], up: 1'b0};

        sprite_mover #(
            .STEP_TICKS    (STEP_TICKS),
            .SPRITE_INDEX  (i + 1),
            .START_X       (play_pkg::BOT_START_X[i]),
            .START_Y       (play_pkg::BOT_START_Y),
            .SPRITE_COLOUR (screen_pkg::COLOUR_BOT),
            .IS_PLAYER     (1'b0)
        ) u_mover (
            .clock      (clock),
            .reset      (reset),
            .step_count (step_count),
            .move_req   (bot_move),
            .pos_x      (bot_x),
            .pos_y      (bot_y),
            .pixel_req  (pixel_req[i+1])
        );

        bot_health #(.HIT_TICKS(HIT_TICKS)) u_health (
            .clock    (clock),
            .reset    (reset),
            .revive   (bot_revive[i]),
            .player_x (player_x),
            .player_y (player_y),
            .bot_x    (bot_x),
            .bot_y    (bot_y),
            .health   (bot_health[i]),
            .alive    (bot_alive[i])
        );
    end

    score_timer #(.N_BOTS(N_BOTS), .SCORE_TICKS(SCORE_TICKS)) u_score (
        .clock      (clock),
        .reset      (reset),
        .bots_alive (bot_alive),
        .score      (score)
    );

    pixel_arbiter #(.N_BOTS(N_BOTS)) u_arbiter (
        .clock     (clock),
        .reset     (reset),
        .pixel_req (pixel_req),
        .pixel     (pixel)
    );

endmodule

//--- design/pixel_arbiter.sv
// ======================================================================
// pixel arbiter
// registered fixed priority merge of all sprite writes, the lowest
// index with plot high wins
// ======================================================================
`timescale 1ns/1ps

module pixel_arbiter #(
    parameter int N_BOTS = 3
) (
    input  logic                        clock,
    input  logic                        reset,
    input  screen_pkg::pixel_t [N_BOTS:0] pixel_req,  // index 0 is the player
    output screen_pkg::pixel_t            pixel
);

    screen_pkg::pixel_t sel;

    // scan from the top so the lowest index overwrites last
    always_comb
    begin
        sel = pixel_req[N_BOTS];
        for (int i = N_BOTS - 1; i >= 0; i--)
        begin
            if (pixel_req[i].plot)
                sel = pixel_req[i];
        end
    end

    always_ff @(posedge clock)
    begin
        pixel.x      <= sel.x;
        pixel.y      <= sel.y;
        pixel.colour <= sel.colour;
        if (reset)
            pixel.plot <= 1'b0;
        else
            pixel.plot <= sel.plot;  // low when nobody writes
    end

endmodule

//--- design/play_pkg.sv
// ======================================================================
// game rules package
// health and score types, the direction request record, the sprite
// FSM states and the start positions of all sprites
// ======================================================================
package play_pkg;

    typedef logic [3:0] health_t;
    typedef logic [7:0] score_t;

    localparam health_t FULL_HEALTH = 4'd9;

    // direction levels, right has the highest priority
    typedef struct packed {
        logic right;
        logic left;
        logic down;
        logic up;
    } move_t;

    typedef enum logic [1:0] {
        S_IDLE,   // waiting for the sprite's phase
        S_ERASE,  // black write at the old position
        S_DRAW    // colour write at the new position
    } sprite_state_t;

    // cycles between the phases of neighbouring sprites
    localparam int PHASE_SPACING = 4;

    localparam screen_pkg::x_t PLAYER_START_X = 8'd47;
    localparam screen_pkg::y_t BOT_START_Y    = 7'd1;

    // start column per bot, supports up to five bots
    localparam screen_pkg::x_t BOT_START_X [0:4] = '{8'd42, 8'd63, 8'd79, 8'd95, 8'd111};

endpackage

//--- design/score_timer.sv
// ======================================================================
// score timer
// counts one point every SCORE_TICKS cycles while any bot is alive,
// freezes once all bots are down
// ======================================================================
`timescale 1ns/1ps

module score_timer #(
    parameter int N_BOTS      = 3,
    parameter int SCORE_TICKS = 64
) (
    input  logic              clock,
    input  logic              reset,
    input  logic [N_BOTS-1:0] bots_alive,
    output play_pkg::score_t  score
);

    localparam int DW = (SCORE_TICKS > 1) ? $clog2(SCORE_TICKS) : 1;
    localparam logic [DW-1:0] DIV_LAST = DW'(SCORE_TICKS - 1);

    logic          any_alive;
    logic [DW-1:0] div_count;

    assign any_alive = |bots_alive;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            div_count <= '0;
            score     <= '0;
        end
        else if (any_alive)
        begin
            if (div_count == DIV_LAST)
            begin
                div_count <= '0;
                score     <= score + 1'b1;  // wraps at 8 bits
            end
            else
                div_count <= div_count + 1'b1;
        end
    end

endmodule

//--- design/screen_pkg.sv
// ======================================================================
// screen geometry package
// frame buffer size, pixel coordinate types, sprite colours and the
// pixel write record that flows from the sprites to the arbiter
// ======================================================================
package screen_pkg;

    typedef logic [7:0] x_t;       // pixel column, 0..159
    typedef logic [6:0] y_t;       // pixel row, 0..119
    typedef logic [2:0] colour_t;  // r,g,b one bit each

    // one pixel write, plot is the strobe
    typedef struct packed {
        logic    plot;
        x_t      x;
        y_t      y;
        colour_t colour;
    } pixel_t;

    localparam int SCREEN_W = 160;
    localparam int SCREEN_H = 120;

    // bots land here, the player starts here
    localparam y_t BOTTOM_ROW = 7'd112;

    localparam colour_t COLOUR_BLACK  = 3'b000;  // erase colour
    localparam colour_t COLOUR_PLAYER = 3'b110;  // yellow
    localparam colour_t COLOUR_BOT    = 3'b111;  // white

endpackage

//--- design/sprite_mover.sv
// ======================================================================
// sprite mover
// per-sprite FSM and position register, on its phase it picks a
// direction, then emits an erase write and a draw write
// ======================================================================
`timescale 1ns/1ps

module sprite_mover #(
    parameter int                  STEP_TICKS    = 32,
    parameter int                  SPRITE_INDEX  = 0,
    parameter screen_pkg::x_t      START_X       = 8'd0,
    parameter screen_pkg::y_t      START_Y       = 7'd0,
    parameter screen_pkg::colour_t SPRITE_COLOUR = 3'b111,
    parameter bit                  IS_PLAYER     = 1'b0
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [$clog2(STEP_TICKS)-1:0] step_count,
    input  play_pkg::move_t               move_req,
    output screen_pkg::x_t                pos_x,
    output screen_pkg::y_t                pos_y,
    output screen_pkg::pixel_t            pixel_req
);

    localparam int CW = $clog2(STEP_TICKS);
    // phase slot of this sprite inside the step period
    localparam logic [CW-1:0] PHASE = CW'(SPRITE_INDEX * play_pkg::PHASE_SPACING);
    localparam screen_pkg::x_t RIGHT_EDGE = screen_pkg::x_t'(screen_pkg::SCREEN_W - 1);

    play_pkg::sprite_state_t state;
    play_pkg::move_t         want;   // request after masking for bots
    play_pkg::move_t         pick;   // chosen direction, one-hot or zero
    play_pkg::move_t         dir;    // direction latched at fire time
    logic                    fire;

    // bots only ever fall
    always_comb
    begin
        want = move_req;
        if (!IS_PLAYER)
        begin
            want.right = 1'b0;
            want.left  = 1'b0;
            want.up    = 1'b0;
        end
    end

    // priority right, left, down, up, then the edge check
    always_comb
    begin
        pick = '0;
        if (want.right)
            pick.right = (pos_x < RIGHT_EDGE);
        else if (want.left)
            pick.left = (pos_x != '0);
        else if (want.down)
            pick.down = (pos_y < screen_pkg::BOTTOM_ROW);  // bottom test is on the row
        else if (want.up)
            pick.up = (pos_y != '0);
    end

    assign fire = (state == play_pkg::S_IDLE) && (step_count == PHASE) && (pick != '0);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= play_pkg::S_IDLE;
            pos_x <= START_X;
            pos_y <= START_Y;
        end
        else
        begin
            case (state)
                play_pkg::S_IDLE:
                begin
                    if (fire)
                        state <= play_pkg::S_ERASE;
                end
                play_pkg::S_ERASE:
                begin
                    // erase goes out this cycle, position moves at its end
                    if (dir.right)
                        pos_x <= pos_x + 1'b1;
                    else if (dir.left)
                        pos_x <= pos_x - 1'b1;
                    else if (dir.down)
                        pos_y <= pos_y + 1'b1;
                    else if (dir.up)
                        pos_y <= pos_y - 1'b1;
                    state <= play_pkg::S_DRAW;
                end
                play_pkg::S_DRAW:
                    state <= play_pkg::S_IDLE;
                default:
                    state <= play_pkg::S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (fire)
            dir <= pick;  // hold the choice through the erase cycle
    end

    // write request straight from the state
    always_comb
    begin
        pixel_req.plot   = 1'b0;
        pixel_req.x      = pos_x;
        pixel_req.y      = pos_y;
        pixel_req.colour = SPRITE_COLOUR;
        case (state)
            play_pkg::S_ERASE:
            begin
                pixel_req.plot   = 1'b1;
                pixel_req.colour = screen_pkg::COLOUR_BLACK;  // old position
            end
            play_pkg::S_DRAW:
                pixel_req.plot = 1'b1;                        // new position
            default:
                pixel_req.plot = 1'b0;
        endcase
    end

endmodule

//--- design/step_timer.sv
// ======================================================================
// step timer
// free running counter shared by all sprites, each sprite fires when
// the count matches its own phase
// ======================================================================
`timescale 1ns/1ps

module step_timer #(
    parameter int STEP_TICKS = 32
) (
    input  logic                          clock,
    input  logic                          reset,
    output logic [$clog2(STEP_TICKS)-1:0] step_count
);

    localparam int CW = $clog2(STEP_TICKS);
    localparam logic [CW-1:0] LAST = CW'(STEP_TICKS - 1);

    always_ff @(posedge clock)
    begin
        if (reset)
            step_count <= '0;
        else if (step_count == LAST)
            step_count <= '0;                 // wrap, next step period
        else
            step_count <= step_count + 1'b1;
    end

endmodule

//--- sim.f
design/screen_pkg.sv
design/play_pkg.sv
design/step_timer.sv
design/sprite_mover.sv
design/bot_health.sv
design/score_timer.sv
design/pixel_arbiter.sv
design/pc_defender_top.sv
verification/pc_defender_asserts.sv
verification/pc_defender_tb.sv

//--- verification/pc_defender_asserts.sv
// ======================================================================
// pc defender assertions
// bound into the top level, watches the pixel strobe after reset,
// the health range, health rises and the score step size
// ======================================================================
`timescale 1ns/1ps

module pc_defender_asserts #(
    parameter int N_BOTS = 3
) (
    input  logic                           clock,
    input  logic                           reset,
    input  screen_pkg::pixel_t             pixel,
    input  logic [N_BOTS-1:0]              bot_revive,
    input  play_pkg::health_t [N_BOTS-1:0] bot_health,
    input  play_pkg::score_t               score
);

    // strobe is quiet right after a reset edge
    plot_after_reset: assert property (@(posedge clock) reset |=> !pixel.plot)
        else $error("pixel plot high in the cycle after reset");

    for (genvar k = 0; k < N_BOTS; k++)
    begin : g_health
        health_range: assert property (@(posedge clock) disable iff (reset)
            bot_health[k] <= play_pkg::FULL_HEALTH)
            else $error("bot %0d health above full", k);

        // only a revive can push health up
        health_rise: assert property (@(posedge clock) disable iff (reset)
            (bot_health[k] > $past(bot_health[k])) |-> $past(bot_revive[k]))
            else $error("bot %0d health rose without revive", k);
    end

    score_step: assert property (@(posedge clock) disable iff (reset)
        (score == $past(score)) || (score == play_pkg::score_t'($past(score) + 1'b1)))
        else $error("score jumped by more than one");

endmodule

bind pc_defender_top pc_defender_asserts #(.N_BOTS(N_BOTS)) u_asserts (
    .clock      (clock),
    .reset      (reset),
    .pixel      (pixel),
    .bot_revive (bot_revive),
    .bot_health (bot_health),
    .score      (score)
);

//--- verification/pc_defender_tb.sv
// ======================================================================
// pc defender testbench
// table driven player moves and revive pulses, a model of all sprite
// positions built from the write stream, checks on health and score
// ======================================================================
`timescale 1ns/1ps

module pc_defender_tb;

    localparam int N_BOTS      = 3;
    localparam int STEP_TICKS  = 32;
    localparam int HIT_TICKS   = 8;
    localparam int SCORE_TICKS = 64;
    localparam int N_ROWS      = 15;

    localparam play_pkg::move_t MV_NONE  = 4'b0000;
    localparam play_pkg::move_t MV_RIGHT = 4'b1000;  // right is the top bit
    localparam play_pkg::move_t MV_LEFT  = 4'b0100;

    // one stimulus row, healths checked at its last cycle
    typedef struct packed {
        play_pkg::move_t                move;
        logic [N_BOTS-1:0]              revive;
        int                             hold;        // cycles, whole steps
        play_pkg::health_t [N_BOTS-1:0] exp_health;
        logic                           frozen;      // score must hold
    } row_t;

    logic                           clock;
    logic                           reset;
    play_pkg::move_t                player_move;
    logic [N_BOTS-1:0]              bot_revive;
    screen_pkg::pixel_t             pixel;
    play_pkg::health_t [N_BOTS-1:0] bot_health;
    play_pkg::score_t               score;

    row_t              rows [N_ROWS];
    screen_pkg::x_t    model_px;             // player, tracked from writes
    screen_pkg::y_t    model_py;
    screen_pkg::y_t    model_by [N_BOTS];    // bot rows, columns never change
    logic              erase_pending;
    screen_pkg::x_t    erase_x;
    screen_pkg::y_t    erase_y;
    play_pkg::health_t last_health [N_BOTS];
    int                bot_draws [N_BOTS];
    int                player_draws;
    int                cycles;               // since reset release
    int                value_errors;
    int                timeouts;
    logic              ever_frozen;

    pc_defender_top #(
        .N_BOTS      (N_BOTS),
        .STEP_TICKS  (STEP_TICKS),
        .HIT_TICKS   (HIT_TICKS),
        .SCORE_TICKS (SCORE_TICKS)
    ) DUT (
        .clock       (clock),
        .reset       (reset),
        .player_move (player_move),
        .bot_revive  (bot_revive),
        .pixel       (pixel),
        .bot_health  (bot_health),
        .score       (score)
    );

    always #50 clock = ~clock;  // 100 ns period

    function automatic row_t make_row(play_pkg::move_t m, logic [N_BOTS-1:0] rv, int steps,
                                      int h0, int h1, int h2, logic frz);
        row_t r;
        r.move          = m;
        r.revive        = rv;
        r.hold          = steps * STEP_TICKS;
        r.exp_health[0] = play_pkg::health_t'(h0);
        r.exp_health[1] = play_pkg::health_t'(h1);
        r.exp_health[2] = play_pkg::health_t'(h2);
        r.frozen        = frz;
        return r;
    endfunction

    // one player step by priority and screen edges, packed as {x, y}
    function automatic logic [14:0] player_step(play_pkg::move_t m, screen_pkg::x_t x,
                                                screen_pkg::y_t y);
        screen_pkg::x_t nx;
        screen_pkg::y_t ny;
        nx = x;
        ny = y;
        if (m.right)
        begin
            if (x < screen_pkg::x_t'(screen_pkg::SCREEN_W - 1))
                nx = x + 8'd1;
        end
        else if (m.left)
        begin
            if (x != 8'd0)
                nx = x - 8'd1;
        end
        else if (m.down)
        begin
            if (y < screen_pkg::BOTTOM_ROW)
                ny = y + 7'd1;
        end
        else if (m.up)
        begin
            if (y != 7'd0)
                ny = y - 7'd1;
        end
        return {nx, ny};
    endfunction

    task automatic value_error(input string msg);
        value_errors++;
        $display("ERR @%0t ns: %s", $time, msg);
    endtask

    // follows erase then draw pairs and moves the model
    task automatic check_pixel();
        screen_pkg::pixel_t p;
        logic [14:0]        nxt;
        int                 hit;
        p = pixel;
        if (!p.plot)
            return;
        assert (p.colour == screen_pkg::COLOUR_BLACK || p.colour == screen_pkg::COLOUR_PLAYER
                || p.colour == screen_pkg::COLOUR_BOT)
            else value_error($sformatf("write with unknown colour %0d", p.colour));
        if (p.colour == screen_pkg::COLOUR_BLACK)
        begin
            assert (!erase_pending) else value_error("two erases in a row");
            erase_pending = 1'b1;
            erase_x       = p.x;
            erase_y       = p.y;
        end
        else if (p.colour == screen_pkg::COLOUR_PLAYER)
        begin
            nxt = player_step(player_move, model_px, model_py);
            assert (erase_pending && erase_x == model_px && erase_y == model_py)
                else value_error($sformatf("player erase at %0d,%0d, model %0d,%0d",
                                           erase_x, erase_y, model_px, model_py));
            assert ({p.x, p.y} == nxt)
                else value_error($sformatf("player drawn at %0d,%0d, expected %0d,%0d",
                                           p.x, p.y, nxt[14:7], nxt[6:0]));
            model_px = nxt[14:7];
            model_py = nxt[6:0];
            player_draws++;
            erase_pending = 1'b0;
        end
        else if (p.colour == screen_pkg::COLOUR_BOT)
        begin
            hit = -1;
            for (int k = 0; k < N_BOTS; k++)
                if (p.x == play_pkg::BOT_START_X[k])
                    hit = k;
            assert (hit >= 0) else value_error($sformatf("bot write in empty column %0d", p.x));
            if (hit >= 0)
            begin
                assert (erase_pending && erase_x == p.x && erase_y == model_by[hit])
                    else value_error($sformatf("bot %0d erase at %0d,%0d", hit, erase_x, erase_y));
                assert (model_by[hit] < screen_pkg::BOTTOM_ROW && p.y == model_by[hit] + 7'd1)
                    else value_error($sformatf("bot %0d drawn at row %0d, model row %0d",
                                               hit, p.y, model_by[hit]));
                if (model_by[hit] < screen_pkg::BOTTOM_ROW)
                    model_by[hit] = model_by[hit] + 7'd1;  // one row per step
                bot_draws[hit]++;
            end
            erase_pending = 1'b0;
        end
    endtask

    // one clock, outputs sampled on the falling edge
    task automatic tick();
        @(negedge clock);
        cycles++;
        check_pixel();
        if (cycles <= 5)
            assert (!pixel.plot) else value_error("write before the first bot step");
        for (int k = 0; k < N_BOTS; k++)
        begin
            if (!bot_revive[k])
                assert (bot_health[k] <= last_health[k])
                    else value_error($sformatf("bot %0d health rose to %0d", k, bot_health[k]));
            last_health[k] = bot_health[k];
        end
    endtask

    task automatic run_row(input row_t r, input int idx);
        play_pkg::score_t score_start;
        logic [14:0]      predicted;
        logic [14:0]      nxt;
        int               expect_steps;
        int               draws_start;
        int               ideal;
        int               dead_at [N_BOTS];
        player_move  = r.move;
        bot_revive   = r.revive;
        score_start  = score;
        draws_start  = player_draws;
        predicted    = {model_px, model_py};
        expect_steps = 0;
        for (int s = 0; s < r.hold / STEP_TICKS; s++)
        begin
            nxt = player_step(r.move, predicted[14:7], predicted[6:0]);
            if (nxt != predicted)
                expect_steps++;
            predicted = nxt;
        end
        for (int k = 0; k < N_BOTS; k++)
            dead_at[k] = -1;
        // bounded wait, the row length is the timeout for any death
        for (int c = 0; c < r.hold; c++)
        begin
            tick();
            if (r.frozen)
                assert (score == score_start) else value_error("score moved while frozen");
            for (int k = 0; k < N_BOTS; k++)
                if (dead_at[k] < 0 && bot_health[k] == 4'd0)
                    dead_at[k] = c;
        end
        for (int k = 0; k < N_BOTS; k++)
        begin
            assert (bot_health[k] == r.exp_health[k])
                else value_error($sformatf("row %0d bot %0d health %0d, expected %0d",
                                           idx, k, bot_health[k], r.exp_health[k]));
            if (r.exp_health[k] == 4'd0)
                assert (dead_at[k] >= 0)
                else
                begin
                    timeouts++;
                    $display("timeout: bot %0d did not reach zero health within %0d cycles",
                             k, r.hold);
                end
        end
        assert (player_draws - draws_start == expect_steps && {model_px, model_py} == predicted)
            else value_error($sformatf("row %0d player made %0d steps, expected %0d",
                                       idx, player_draws - draws_start, expect_steps));
        if (r.frozen)
            ever_frozen = 1'b1;
        else if (r.exp_health != '0)
        begin
            if (r.hold >= SCORE_TICKS)
                assert (score != score_start) else value_error("score did not advance");
            ideal = cycles / SCORE_TICKS;
            if (!ever_frozen)
                assert (int'(score) >= ideal - 1 && int'(score) <= ideal + 1)
                    else value_error($sformatf("score %0d after %0d cycles", score, cycles));
        end
    endtask

    initial
    begin
        clock         = 1'b0;
        reset         = 1'b1;
        player_move   = MV_NONE;
        bot_revive    = '0;
        model_px      = play_pkg::PLAYER_START_X;
        model_py      = screen_pkg::BOTTOM_ROW;
        erase_pending = 1'b0;
        erase_x       = '0;
        erase_y       = '0;
        player_draws  = 0;
        cycles        = 0;
        value_errors  = 0;
        timeouts      = 0;
        ever_frozen   = 1'b0;
        for (int k = 0; k < N_BOTS; k++)
        begin
            model_by[k]    = play_pkg::BOT_START_Y;
            bot_draws[k]   = 0;
            last_health[k] = play_pkg::FULL_HEALTH;
        end

        rows[0]  = make_row(MV_NONE,  3'b000,  1, 9, 9, 9, 1'b0);  // reset idle
        rows[1]  = make_row(MV_RIGHT, 3'b000,  3, 9, 9, 9, 1'b0);  // 47 to 50
        rows[2]  = make_row(MV_LEFT,  3'b000, 50, 9, 9, 9, 1'b0);  // to column 0
        rows[3]  = make_row(MV_LEFT,  3'b000,  3, 9, 9, 9, 1'b0);  // blocked by edge
        rows[4]  = make_row(MV_NONE,  3'b000, 64, 9, 9, 9, 1'b0);  // bots land
        rows[5]  = make_row(MV_RIGHT, 3'b000, 42, 6, 9, 9, 1'b0);  // onto bot 0
        rows[6]  = make_row(MV_NONE,  3'b000,  4, 0, 9, 9, 1'b0);
        rows[7]  = make_row(MV_RIGHT, 3'b000, 21, 0, 6, 9, 1'b0);  // onto bot 1
        rows[8]  = make_row(MV_NONE,  3'b000,  4, 0, 0, 9, 1'b0);
        rows[9]  = make_row(MV_RIGHT, 3'b000, 16, 0, 0, 6, 1'b0);  // onto bot 2
        rows[10] = make_row(MV_NONE,  3'b000,  4, 0, 0, 0, 1'b0);
        rows[11] = make_row(MV_NONE,  3'b000,  8, 0, 0, 0, 1'b1);  // all down
        rows[12] = make_row(MV_LEFT,  3'b000,  1, 0, 0, 0, 1'b1);  // step off bot 2
        rows[13] = make_row(MV_NONE,  3'b100,  1, 0, 0, 9, 1'b0);  // revive bot 2
        rows[14] = make_row(MV_NONE,  3'b000,  4, 0, 0, 9, 1'b0);  // score runs again

        repeat (8) @(negedge clock);
        reset = 1'b0;
        assert (!pixel.plot && score == 8'd0) else value_error("pixel or score not cleared");
        for (int k = 0; k < N_BOTS; k++)
            assert (bot_health[k] == play_pkg::FULL_HEALTH)
                else value_error($sformatf("bot %0d health %0d after reset", k, bot_health[k]));

        for (int i = 0; i < N_ROWS; i++)
            run_row(rows[i], i);

        // every bot fell the full height and then stopped
        for (int k = 0; k < N_BOTS; k++)
            assert (model_by[k] == screen_pkg::BOTTOM_ROW
                    && bot_draws[k] == int'(screen_pkg::BOTTOM_ROW) - int'(play_pkg::BOT_START_Y))
                else value_error($sformatf("bot %0d made %0d draws", k, bot_draws[k]));
        assert (!erase_pending) else value_error("erase left without a draw");

        $display("error counts: %0d value errors, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule
